/* files.f */
source/avmm_host_wr_pkg.sv
source/burst_splitter.sv
source/irq_tracker.sv
source/burst_fifo.sv
source/write_response.sv
source/avmm_host_wr.sv
dv/avmm_host_wr_assert.sv
dv/avmm_host_wr_tb.sv

/* Makefile */
TOP := avmm_host_wr_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) --Mdir obj_dir

# the run fails unless the simulation prints the pass message
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dv/avmm_host_wr_tb.sv */
/*
 * testbench for the Avalon host write slave
 * drives bursts and interrupts, models host responses and checks every request
 */
`timescale 1ns/1ns
`default_nettype none

module avmm_host_wr_tb
	import avmm_host_wr_pkg::*;
();

	localparam int accept_limit = 500;
	localparam int drain_limit = 3000;

	// one expected memory write as the reference builds it
	typedef struct packed {
		cl_len_e cl_len;
		logic sop;
		line_addr_t address;
		line_data_t data;
	} exp_beat_t;

	logic clk = 1'b0;
	logic reset;
	logic write;
	byte_addr_t address;
	burst_t burstcount;
	line_data_t writedata;
	logic waitrequest;
	logic write_responsevalid;
	logic tx_almost_full;
	tx_req_t tx;
	rx_rsp_t rx;
	irq_vec_t irq;

	exp_beat_t exp_q[$];
	int irq_exp_q[$];
	int burst_len_q[$];
	int rsp_due_q[$];
	logic [1:0] rsp_num_q[$];
	mdata_t tag_count = '0;
	int cycle = 0;
	int last_due = 0;
	int lines_owed = 0;
	int lines_returned = 0;
	int lines_needed = 0;
	int bursts_sent = 0;
	int rsp_pulses = 0;
	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic bp_on = 1'b0;
	logic rsp_hold = 1'b0;

	avmm_host_wr i_avmm_host_wr (
		.clk(clk),
		.reset(reset),
		.write(write),
		.address(address),
		.burstcount(burstcount),
		.writedata(writedata),
		.waitrequest(waitrequest),
		.write_responsevalid(write_responsevalid),
		.tx_almost_full(tx_almost_full),
		.tx(tx),
		.rx(rx),
		.irq(irq)
	);

	initial
	begin
		forever #2 clk = ~clk;
	end

	// **************************************************
	// reporting
	// **************************************************

	task automatic report_mismatch(string name, line_data_t got, line_data_t want);
		$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, want);
		errors++;
	endtask

	task automatic fail_note(string what);
		$display("at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic abort_run(string what);
		$display("at %0t: timed out waiting for %s", $time, what);
		errors++;
		$display("test failed");
		$finish;
	endtask

	task automatic finish_test(string name);
		int errs;
		errs = errors - errors_at_start;
		tests_run++;
		if (errs != 0)
			tests_failed++;
		$display("%s: %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
		errors_at_start = errors;
	endtask

	// **************************************************
	// reference model
	// **************************************************

	// builds the header of one beat of a burst straight from the mapping rules
	function automatic tx_hdr_t ref_header(byte_addr_t addr, int len, int beat);
		tx_hdr_t h;
		line_addr_t line;
		logic aligned;
		line = addr[byte_addr_width-1:6];
		aligned = (len == 1) || (len == 2 && line[0] == 1'b0)
			|| (len == 4 && line[1:0] == 2'b00);
		h = '0;
		h.req_type = req_wrline;
		h.address = line + line_addr_t'(beat);
		if (!aligned)
		begin
			h.cl_len = cl_len_1;
			h.sop = 1'b1;
		end
		else
		begin
			h.cl_len = (len == 4) ? cl_len_4 : ((len == 2) ? cl_len_2 : cl_len_1);
			h.sop = (beat == 0);
		end
		return h;
	endfunction

	function automatic line_data_t random_line();
		line_data_t d;
		for (int i = 0; i < line_data_width / 32; i++)
			d[i*32 +: 32] = $urandom;
		return d;
	endfunction

	function automatic int pick_len(bit chopped);
		int r;
		r = int'($urandom_range(0, 2));
		if (chopped)
			return 2 + r;
		return (r == 2) ? 4 : r + 1;
	endfunction

	// picks a random burst address that sits either on the burst's own size or off it
	function automatic byte_addr_t burst_addr(int len, bit aligned);
		line_addr_t line;
		line = line_addr_t'({$urandom, $urandom});
		// keep well below the top so a burst never wraps
		line[line_addr_width-1] = 1'b0;
		if (aligned && len == 2)
			line[0] = 1'b0;
		else if (aligned && len == 4)
			line[1:0] = 2'b00;
		else if (!aligned && len == 2)
			line[0] = 1'b1;
		else if (!aligned && len == 4 && line[1:0] == 2'b00)
			line[0] = 1'b1;
		return {line, 6'b0};
	endfunction

	// **************************************************
	// stimulus
	// **************************************************

	task automatic write_burst(byte_addr_t addr, int len);
		tx_hdr_t h;
		exp_beat_t e;
		line_data_t d;
		int waited;
		for (int beat = 0; beat < len; beat++)
		begin
			d = random_line();
			h = ref_header(addr, len, beat);
			@(negedge clk);
			write = 1'b1;
			address = addr;
			burstcount = burst_t'(len);
			writedata = d;
			waited = 0;
			#1;
			// signals stay put until the DUT lets the beat through
			while (waitrequest && waited < accept_limit)
			begin
				@(negedge clk);
				#1;
				waited++;
			end
			if (waitrequest)
				abort_run("a write beat to be accepted");
			e.cl_len = h.cl_len;
			e.sop = h.sop;
			e.address = h.address;
			e.data = d;
			exp_q.push_back(e);
			if (beat == 0)
			begin
				burst_len_q.push_back(len);
				bursts_sent++;
			end
			@(posedge clk);
		end
		@(negedge clk);
		write = 1'b0;
	endtask

	// raises a group of lines for one cycle and expects the lowest index first
	task automatic pulse_irqs(irq_vec_t group);
		int waited;
		@(negedge clk);
		irq = group;
		for (int i = 0; i < irq_lines; i++)
		begin
			if (group[i])
				irq_exp_q.push_back(i);
		end
		@(negedge clk);
		irq = '0;
		waited = 0;
		#1;
		while (irq_exp_q.size() != 0 && waited < drain_limit)
		begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (irq_exp_q.size() != 0)
			abort_run("interrupt requests");
	endtask

	function automatic bit all_done(bit need_responses);
		if (exp_q.size() != 0 || irq_exp_q.size() != 0)
			return 1'b0;
		return !need_responses || (rsp_pulses == bursts_sent);
	endfunction

	task automatic wait_drain(bit need_responses, string what);
		int waited;
		waited = 0;
		while (!all_done(need_responses) && waited < drain_limit)
		begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (!all_done(need_responses))
			abort_run(what);
	endtask

	// the host applies random back-pressure while it is enabled
	initial
	begin
		tx_almost_full = 1'b0;
		forever
		begin
			@(negedge clk);
			tx_almost_full = bp_on && ($urandom_range(0, 2) == 0);
		end
	end

	// **************************************************
	// checker and host response model
	// **************************************************

	task automatic check_write();
		exp_beat_t e;
		int due;
		if (exp_q.size() == 0)
		begin
			fail_note("a write request came out with no beat expected");
			return;
		end
		e = exp_q.pop_front();
		assert (tx.hdr.req_type == req_wrline)
			else report_mismatch("tx.hdr.req_type", line_data_t'(tx.hdr.req_type),
				line_data_t'(req_wrline));
		assert (tx.hdr.cl_len == e.cl_len)
			else report_mismatch("tx.hdr.cl_len", line_data_t'(tx.hdr.cl_len),
				line_data_t'(e.cl_len));
		assert (tx.hdr.sop == e.sop)
			else report_mismatch("tx.hdr.sop", line_data_t'(tx.hdr.sop), line_data_t'(e.sop));
		assert (tx.hdr.address == e.address)
			else report_mismatch("tx.hdr.address", line_data_t'(tx.hdr.address),
				line_data_t'(e.address));
		assert (tx.data == e.data)
			else report_mismatch("tx.data", tx.data, e.data);
		// every request before this one took one tag
		assert (tx.hdr.mdata == tag_count)
			else report_mismatch("tx.hdr.mdata", line_data_t'(tx.hdr.mdata),
				line_data_t'(tag_count));
		if (tx.hdr.sop)
		begin
			assert (lines_owed == 0)
				else fail_note("a new request began before the last one was complete");
			lines_owed = int'(tx.hdr.cl_len);
			// the host answers each request once, after a random delay
			due = cycle + int'($urandom_range(1, 8));
			if (due < last_due)
				due = last_due;
			last_due = due;
			rsp_due_q.push_back(due);
			rsp_num_q.push_back(tx.hdr.cl_len);
		end
		else
		begin
			assert (lines_owed > 0)
				else fail_note("a write with sop low came outside a multi-line request");
			if (lines_owed > 0)
				lines_owed--;
		end
	endtask

	task automatic check_irq();
		int want;
		assert (lines_owed == 0)
			else fail_note("an interrupt came between the beats of a multi-line request");
		if (irq_exp_q.size() == 0)
			fail_note("an interrupt request came out with none pending");
		else
		begin
			want = irq_exp_q.pop_front();
			assert (tx.hdr.mdata == mdata_t'(want))
				else report_mismatch("tx.hdr.mdata", line_data_t'(tx.hdr.mdata),
					line_data_t'(want));
		end
	endtask

	task automatic check_response();
		rsp_pulses++;
		if (burst_len_q.size() == 0)
		begin
			fail_note("a write response came with no burst outstanding");
			return;
		end
		lines_needed += burst_len_q.pop_front();
		assert (lines_needed <= lines_returned)
			else fail_note("a write response came before the lines of its burst returned");
	endtask

	task automatic drive_response();
		rx_rsp_t r;
		r.valid = 1'b0;
		r.resp_type = rsp_wrline;
		r.cl_num = 2'd0;
		if (!rsp_hold && rsp_due_q.size() != 0 && rsp_due_q[0] <= cycle)
		begin
			void'(rsp_due_q.pop_front());
			r.valid = 1'b1;
			r.cl_num = rsp_num_q.pop_front();
			lines_returned += int'(r.cl_num) + 1;
		end
		else if ($urandom_range(0, 7) == 0)
		begin
			// now and then a response of another kind comes back and must not count
			r.valid = 1'b1;
			r.resp_type = rsp_other;
			r.cl_num = 2'd3;
		end
		rx = r;
	endtask

	// tx and the response pulse are registered, so the falling edge sees them settled
	initial
	begin
		rx = '0;
		forever
		begin
			@(negedge clk);
			cycle++;
			if (!reset)
			begin
				if (tx.valid)
				begin
					if (tx.hdr.req_type == req_intr)
						check_irq();
					else
						check_write();
					tag_count = tag_count + mdata_t'(1);
				end
				if (write_responsevalid)
					check_response();
			end
			drive_response();
		end
	end

	// **************************************************
	// test sequence
	// **************************************************

	initial
	begin
		int len;
		void'($urandom(62));
		reset = 1'b1;
		write = 1'b0;
		address = '0;
		burstcount = '0;
		writedata = '0;
		irq = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < 12; i++)
		begin
			len = pick_len(1'b0);
			write_burst(burst_addr(len, 1'b1), len);
		end
		wait_drain(1'b1, "aligned bursts to complete");
		finish_test("aligned bursts");

		for (int i = 0; i < 12; i++)
		begin
			len = pick_len(1'b1);
			write_burst(burst_addr(len, 1'b0), len);
		end
		wait_drain(1'b1, "chopped bursts to complete");
		finish_test("chopped bursts");

		bp_on = 1'b1;
		for (int i = 0; i < 40; i++)
		begin
			len = int'($urandom_range(1, 4));
			write_burst(burst_addr(len, 1'($urandom_range(0, 1))), len);
		end
		wait_drain(1'b1, "bursts under back-pressure to complete");
		bp_on = 1'b0;
		finish_test("back-pressure");

		// interrupts land while four line bursts are in flight
		fork
			begin
				for (int i = 0; i < 16; i++)
					write_burst(burst_addr(4, 1'($urandom_range(0, 1))), 4);
			end
			begin
				pulse_irqs(4'b0001);
				pulse_irqs(4'b1010);
				pulse_irqs(4'b0110);
				pulse_irqs(4'b1111);
				pulse_irqs(4'b0100);
			end
		join
		wait_drain(1'b1, "bursts and interrupts to complete");
		finish_test("interrupts");

		// fill the burst FIFO with responses held back
		rsp_hold = 1'b1;
		for (int i = 0; i < burst_fifo_depth; i++)
		begin
			len = int'($urandom_range(1, 4));
			write_burst(burst_addr(len, 1'($urandom_range(0, 1))), len);
		end
		wait_drain(1'b0, "held bursts to be sent");
		fork
			write_burst(burst_addr(1, 1'b1), 1);
			begin
				@(negedge clk);
				repeat (10)
				begin
					#1;
					assert (waitrequest)
						else fail_note("waitrequest dropped while the burst FIFO was full");
					@(negedge clk);
				end
				#1;
				rsp_hold = 1'b0;
			end
		join
		wait_drain(1'b1, "held responses to drain");
		// a quiet spell after the drain shows up any extra response pulse
		repeat (16) @(negedge clk);
		#1;
		assert (rsp_pulses == bursts_sent)
			else report_mismatch("write_responsevalid count", line_data_t'(rsp_pulses),
				line_data_t'(bursts_sent));
		finish_test("write responses");

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/avmm_host_wr_assert.sv */
/*
 * bound checks on the transmit stage and the write response count
 */
`timescale 1ns/1ns
`default_nettype none

module avmm_host_wr_assert (
	input wire logic clk,
	input wire logic reset,
	input wire logic write,
	input wire logic waitrequest,
	input wire logic tx_valid,
	input wire logic burst_start,
	input wire logic write_responsevalid
);

	int unsigned bursts_started;
	int unsigned responses;

	// running totals of bursts opened and responses returned
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bursts_started <= 0;
			responses <= 0;
		end
		else
		begin
			if (burst_start)
				bursts_started <= bursts_started + 1;
			if (write_responsevalid)
				responses <= responses + 1;
		end
	end

	// the transmit register comes out of reset empty
	tx_idle_after_reset: assert property (@(posedge clk) reset |=> !tx_valid)
		else $error("tx.valid high in the cycle after reset");

	// every accepted beat shows up on the transmit channel one cycle later
	beat_to_tx: assert property (@(posedge clk) disable iff (reset)
		(write && !waitrequest) |=> tx_valid)
		else $error("accepted beat did not reach tx on the next cycle");

	// a response pulse always belongs to a burst that is still open
	rsp_within_bursts: assert property (@(posedge clk) disable iff (reset)
		write_responsevalid |-> (responses < bursts_started))
		else $error("more write responses than bursts started");

endmodule

bind avmm_host_wr avmm_host_wr_assert i_avmm_host_wr_assert (
	.clk(clk),
	.reset(reset),
	.write(write),
	.waitrequest(waitrequest),
	.tx_valid(tx.valid),
	.burst_start(burst_start),
	.write_responsevalid(write_responsevalid)
);

`default_nettype wire

/* source/avmm_host_wr.sv */
/*
 * Avalon-MM write slave onto the host transmit channel
 * issues line writes and interrupts and returns write responses per burst
 */
`timescale 1ns/1ns
`default_nettype none

module avmm_host_wr
	import avmm_host_wr_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic write,
	input wire byte_addr_t address,
	input wire burst_t burstcount,
	input wire line_data_t writedata,
	output logic waitrequest,
	output logic write_responsevalid,
	input wire logic tx_almost_full,
	output tx_req_t tx,
	input wire rx_rsp_t rx,
	input wire irq_vec_t irq
);

	// registered copy of the negated almost-full
	logic ready_q;
	logic beat_accept;
	logic at_burst_boundary;
	logic burst_start;
	logic irq_issue;
	irq_id_t irq_id;
	logic fifo_full;
	tx_hdr_t mem_hdr;
	tx_hdr_t irq_hdr;
	tx_hdr_t next_hdr;
	mdata_t mdata_q;
	logic tx_next_valid;

	// **************************************************
	// Avalon handshake
	// **************************************************

	// almost-full leaves room for the one beat that gets in during the lag
	always_ff @(posedge clk)
	begin
		if (reset)
			ready_q <= 1'b0;
		else
			ready_q <= ~tx_almost_full;
	end

	// a full burst FIFO only stalls the beat that would open a burst
	assign waitrequest = ~ready_q | irq_issue | (fifo_full & at_burst_boundary);
	assign beat_accept = write & ~waitrequest;

	burst_splitter i_burst_splitter (
		.clk(clk),
		.reset(reset),
		.write(write),
		.address(address),
		.burstcount(burstcount),
		.beat_accept(beat_accept),
		.start_allowed(~fifo_full),
		.mdata(mdata_q),
		.mem_hdr(mem_hdr),
		.at_burst_boundary(at_burst_boundary),
		.burst_start(burst_start)
	);

	irq_tracker i_irq_tracker (
		.clk(clk),
		.reset(reset),
		.irq(irq),
		.at_burst_boundary(at_burst_boundary),
		.tx_almost_full(tx_almost_full),
		.irq_issue(irq_issue),
		.irq_id(irq_id)
	);

	write_response i_write_response (
		.clk(clk),
		.reset(reset),
		.burst_start(burst_start),
		.burstcount(burstcount),
		.rx(rx),
		.fifo_full(fifo_full),
		.write_responsevalid(write_responsevalid)
	);

	// **************************************************
	// request select and transmit stage
	// **************************************************

	// the interrupt number rides in the tag field
	always_comb
	begin
		irq_hdr.req_type = req_intr;
		irq_hdr.cl_len = cl_len_1;
		irq_hdr.sop = 1'b0;
		irq_hdr.address = '0;
		irq_hdr.mdata = mdata_t'(irq_id);
	end

	// waitrequest is high whenever an interrupt goes out so the two never collide
	assign next_hdr = irq_issue ? irq_hdr : mem_hdr;
	assign tx_next_valid = beat_accept | irq_issue;

	// the tag steps once per request of either kind
	always_ff @(posedge clk)
	begin
		if (reset)
			mdata_q <= '0;
		else if (tx_next_valid)
			mdata_q <= mdata_q + mdata_t'(1);
	end

	always_ff @(posedge clk)
	begin
		tx.hdr <= next_hdr;
		tx.data <= writedata;
		if (reset)
			tx.valid <= 1'b0;
		else
			tx.valid <= tx_next_valid;
	end

endmodule

`default_nettype wire

/* source/write_response.sv */
/*
 * write response tracker
 * folds returning line responses into one Avalon response per burst, in order
 */
`timescale 1ns/1ns
`default_nettype none

module write_response
	import avmm_host_wr_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic burst_start,
	input wire burst_t burstcount,
	input wire rx_rsp_t rx,
	output logic fifo_full,
	output logic write_responsevalid
);

	// lines that came back but are not yet matched to a burst
	rsp_count_t rsp_count;
	rsp_count_t add_lines;
	rsp_count_t sub_lines;
	burst_t head_len;
	logic fifo_empty;
	logic rsp_in;
	logic pop;

	burst_fifo i_burst_fifo (
		.clk(clk),
		.reset(reset),
		.push(burst_start),
		.push_len(burstcount),
		.pop(pop),
		.head_len(head_len),
		.empty(fifo_empty),
		.full(fifo_full)
	);

	// responses are assumed to come back packed
	assign rsp_in = rx.valid & (rx.resp_type == rsp_wrline);

	// the oldest burst completes once enough lines have come back for it
	assign pop = ~fifo_empty & (rsp_count >= rsp_count_t'(head_len));

	assign add_lines = rsp_in ? rsp_count_t'(rx.cl_num) + rsp_count_t'(1) : '0;
	assign sub_lines = pop ? rsp_count_t'(head_len) : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rsp_count <= '0;
			write_responsevalid <= 1'b0;
		end
		else
		begin
			// counts up and down in the same cycle when both happen
			rsp_count <= rsp_count + add_lines - sub_lines;
			// every response is OK so the pulse alone carries it
			write_responsevalid <= pop;
		end
	end

endmodule

`default_nettype wire

/* source/burst_fifo.sv */
/*
 * show-ahead FIFO holding the lengths of Avalon bursts still awaiting a response
 */
`timescale 1ns/1ns
`default_nettype none

module burst_fifo
	import avmm_host_wr_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire burst_t push_len,
	input wire logic pop,
	output burst_t head_len,
	output logic empty,
	output logic full
);

	burst_t mem [burst_fifo_depth];
	logic [burst_fifo_addr_width-1:0] wr_ptr;
	logic [burst_fifo_addr_width-1:0] rd_ptr;
	// one bit wider than the pointers so that full can be told from empty
	logic [burst_fifo_addr_width:0] count;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == (burst_fifo_addr_width + 1)'(burst_fifo_depth));

	// requests against a full or empty FIFO are dropped
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// the head entry is read straight from the array
	assign head_len = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_len;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/irq_tracker.sv */
/*
 * interrupt tracker
 * edge detects the interrupt lines and picks the lowest pending one to send
 */
`timescale 1ns/1ns
`default_nettype none

module irq_tracker
	import avmm_host_wr_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire irq_vec_t irq,
	input wire logic at_burst_boundary,
	input wire logic tx_almost_full,
	output logic irq_issue,
	output irq_id_t irq_id
);

	// previous sample of the lines for the edge detect
	irq_vec_t irq_q;
	irq_vec_t pending;
	irq_vec_t rise;
	irq_vec_t clear;

	assign rise = irq & ~irq_q;

	// lowest index has the highest priority so it is checked last
	always_comb
	begin
		irq_id = '0;
		for (int i = irq_lines - 1; i >= 0; i--)
		begin
			if (pending[i])
				irq_id = irq_id_t'(i);
		end
	end

	// an interrupt never splits a multi line request
	assign irq_issue = (|pending) & at_burst_boundary & ~tx_almost_full;

	// only the chosen bit drops in the cycle its request is registered
	assign clear = irq_issue ? (irq_vec_t'(1) << irq_id) : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			irq_q <= '0;
			pending <= '0;
		end
		else
		begin
			irq_q <= irq;
			// a new edge on the line being cleared keeps it pending
			pending <= (pending & ~clear) | rise;
		end
	end

endmodule

`default_nettype wire

/* source/burst_splitter.sv */
/*
 * burst splitter
 * maps Avalon write bursts onto memory write headers and chops unaligned bursts
 */
`timescale 1ns/1ns
`default_nettype none

module burst_splitter
	import avmm_host_wr_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic write,
	input wire byte_addr_t address,
	input wire burst_t burstcount,
	input wire logic beat_accept,
	input wire logic start_allowed,
	input wire mdata_t mdata,
	output tx_hdr_t mem_hdr,
	output logic at_burst_boundary,
	output logic burst_start
);

	// beats still owed by the current burst after the one being accepted
	logic [1:0] beats_left;
	// line address of the next beat inside a burst
	line_addr_t next_addr;
	// set for the rest of a burst that is being sent as single lines
	logic chop_q;
	// length code captured at the start of the burst
	cl_len_e len_q;
	logic unaligned;
	cl_len_e start_len;
	burst_t burst_minus_one;
	logic step;

	// **************************************************
	// burst tracking
	// **************************************************

	// a zero count means the next beat opens a new burst
	assign at_burst_boundary = (beats_left == 2'd0);

	// start_allowed keeps the counters still when the FIFO can not track one more burst
	assign burst_start = at_burst_boundary & write & beat_accept & start_allowed;
	assign step = write & beat_accept & ~at_burst_boundary;

	// the largest burst is 4 so the remaining count fits in two bits
	assign burst_minus_one = burstcount - burst_t'(1);

	// a burst that does not sit on its own size or has 3 beats is sent one line at a time
	always_comb
	begin
		case (burstcount)
			3'd2: unaligned = address[6];
			3'd3: unaligned = 1'b1;
			3'd4: unaligned = (address[7:6] != 2'b00);
			default: unaligned = 1'b0;
		endcase
	end

	always_comb
	begin
		if (unaligned)
			start_len = cl_len_1;
		else
		begin
			case (burstcount)
				3'd2: start_len = cl_len_2;
				3'd4: start_len = cl_len_4;
				default: start_len = cl_len_1;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			beats_left <= 2'd0;
			chop_q <= 1'b0;
		end
		else if (burst_start)
		begin
			beats_left <= burst_minus_one[1:0];
			chop_q <= unaligned;
		end
		else if (step)
		begin
			beats_left <= beats_left - 2'd1;
			// the last beat of a chopped burst ends the chop
			if (beats_left == 2'd1)
				chop_q <= 1'b0;
		end
	end

	// the counter starts one line past the burst address since beat one uses the input
	always_ff @(posedge clk)
	begin
		if (burst_start)
		begin
			next_addr <= address[byte_addr_width-1:byte_addr_width-line_addr_width]
				+ line_addr_t'(1);
			len_q <= start_len;
		end
		else if (step)
			next_addr <= next_addr + line_addr_t'(1);
	end

	// **************************************************
	// header build
	// **************************************************

	always_comb
	begin
		mem_hdr.req_type = req_wrline;
		mem_hdr.mdata = mdata;
		if (at_burst_boundary)
		begin
			mem_hdr.cl_len = start_len;
			mem_hdr.sop = 1'b1;
			mem_hdr.address = address[byte_addr_width-1:byte_addr_width-line_addr_width];
		end
		else
		begin
			// chopped beats each open their own one line request
			mem_hdr.cl_len = len_q;
			mem_hdr.sop = chop_q;
			mem_hdr.address = next_addr;
		end
	end

endmodule

`default_nettype wire

/* source/avmm_host_wr_pkg.sv */
/*
 * shared widths, encodings and channel structs for the Avalon host write slave
 */
`default_nettype none

package avmm_host_wr_pkg;

	// sizes fixed by the host protocol
	localparam int line_data_width = 512;
	localparam int byte_addr_width = 48;
	localparam int line_addr_width = 42;
	localparam int burst_width = 3;
	localparam int irq_lines = 4;
	localparam int irq_id_width = 2;
	localparam int mdata_width = 16;
	localparam int burst_fifo_depth = 64;
	localparam int burst_fifo_addr_width = 6;
	// worst case is 64 bursts of 4 lines in flight
	localparam int rsp_count_width = 9;

	typedef logic [line_data_width-1:0] line_data_t;
	typedef logic [byte_addr_width-1:0] byte_addr_t;
	typedef logic [line_addr_width-1:0] line_addr_t;
	typedef logic [burst_width-1:0] burst_t;
	typedef logic [irq_lines-1:0] irq_vec_t;
	typedef logic [irq_id_width-1:0] irq_id_t;
	typedef logic [mdata_width-1:0] mdata_t;
	typedef logic [rsp_count_width-1:0] rsp_count_t;

	// code 2 is not a legal length on the host channel
	typedef enum logic [1:0] {
		cl_len_1 = 2'd0,
		cl_len_2 = 2'd1,
		cl_len_4 = 2'd3
	} cl_len_e;

	typedef enum logic [3:0] {
		req_wrline = 4'h0,
		req_intr = 4'h6
	} req_type_e;

	typedef enum logic [3:0] {
		rsp_wrline = 4'h1,
		rsp_other = 4'hf
	} rsp_type_e;

	typedef struct packed {
		req_type_e req_type;
		cl_len_e cl_len;
		logic sop;
		line_addr_t address;
		mdata_t mdata;
	} tx_hdr_t;

	typedef struct packed {
		logic valid;
		tx_hdr_t hdr;
		line_data_t data;
	} tx_req_t;

	// cl_num holds the number of lines minus one
	typedef struct packed {
		logic valid;
		rsp_type_e resp_type;
		logic [1:0] cl_num;
	} rx_rsp_t;

endpackage

`default_nettype wire
